//--- hw/gfx_map_pkg.sv
package gfx_map_pkg;

  // Host bus
  localparam int mpu_addr_width = 16;
  localparam int mpu_data_width = 16;

  // 4K word pages, upper address bits select the page
  localparam int page_offset_width = 12;
  localparam int page_index_width = mpu_addr_width - page_offset_width;

  typedef enum logic [2:0] {
    reg_id,             // Read only
    reg_mem_ctrl,       // Bit 0 display enable, bits 11:8 bank
    reg_scroll_x,
    reg_scroll_y,
    reg_output_status,  // Read only: hsync, vsync, hblank, vblank
    reg_scan_x,         // Read only
    reg_scan_y,         // Read only
    reg_spare
  } reg_index_e;

  localparam logic [mpu_data_width-1:0] id_reg_value = 16'h6c33;

  // Internal address regions
  localparam logic [mpu_addr_width-1:0] main_reg_base = 16'h0000;
  localparam logic [mpu_addr_width-1:0] num_main_regs = 16'd8;
  localparam logic [mpu_addr_width-1:0] pal_addr_base = 16'h1000;
  localparam logic [mpu_addr_width-1:0] pal_addr_length = 16'd512;  // Two words per entry
  localparam logic [mpu_addr_width-1:0] tilemap_addr_base = 16'h2000;
  localparam logic [mpu_addr_width-1:0] tilemap_addr_length = 16'd2048;

  // Fields of the memory control register
  localparam int mem_ctrl_enable_bit = 0;
  localparam int mem_ctrl_bank_lsb = 8;

endpackage

//--- hw/gfx_video_pkg.sv
package gfx_video_pkg;

  localparam int hcount_width = 10;
  localparam int vcount_width = 10;

  // 640x480 timing, sync pulses active low
  localparam logic [hcount_width-1:0] h_visible = 10'd640;
  localparam logic [hcount_width-1:0] h_front = 10'd16;
  localparam logic [hcount_width-1:0] h_sync_len = 10'd96;
  localparam logic [hcount_width-1:0] h_back = 10'd48;
  localparam logic [hcount_width-1:0] h_total = h_visible + h_front + h_sync_len + h_back;
  localparam logic [hcount_width-1:0] h_sync_start = h_visible + h_front;
  localparam logic [hcount_width-1:0] h_sync_end = h_sync_start + h_sync_len;

  localparam logic [vcount_width-1:0] v_visible = 10'd480;
  localparam logic [vcount_width-1:0] v_front = 10'd10;
  localparam logic [vcount_width-1:0] v_sync_len = 10'd2;
  localparam logic [vcount_width-1:0] v_back = 10'd33;
  localparam logic [vcount_width-1:0] v_total = v_visible + v_front + v_sync_len + v_back;
  localparam logic [vcount_width-1:0] v_sync_start = v_visible + v_front;
  localparam logic [vcount_width-1:0] v_sync_end = v_sync_start + v_sync_len;

  // Colour and tile map geometry
  localparam int rgb_depth = 18;
  localparam int color_bits = rgb_depth / 3;
  localparam int pal_index_width = 8;
  localparam int pal_entry_bytes = 3;       // Red, green, blue bytes
  localparam int tile_shift = 3;            // 8x8 tiles
  localparam int map_cols = 64;
  localparam int map_col_bits = $clog2(map_cols);
  localparam int map_addr_width = 11;
  localparam int map_row_bits = map_addr_width - map_col_bits;
  localparam int map_word_width = 16;

endpackage

//--- hw/mpu_bus_decode.sv
`timescale 1ns/100ps

module mpu_bus_decode (
  input  logic clk,
  input  logic reset,
  input  logic mpu_req,
  input  logic mpu_wr,
  input  logic [1:0] mpu_be,
  input  logic [gfx_map_pkg::mpu_addr_width-1:0] mpu_addr,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] mpu_wdata,
  input  logic [gfx_map_pkg::page_index_width-1:0] bank,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] reg_rdata,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] pal_rdata,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] map_rdata,
  output logic mpu_ack,
  output logic [gfx_map_pkg::mpu_data_width-1:0] mpu_rdata,
  output logic acc_en,
  output logic acc_wr,
  output logic [1:0] acc_be,
  output logic [gfx_map_pkg::mpu_addr_width-1:0] int_addr,
  output logic [gfx_map_pkg::mpu_data_width-1:0] wdata,
  output logic reg_sel,
  output logic pal_sel,
  output logic map_sel
);
  import gfx_map_pkg::*;

  typedef enum logic [1:0] {
    bus_idle,
    bus_access,
    bus_hold
  } bus_state_e;

  bus_state_e state;
  logic [page_index_width-1:0] page;
  logic reg_sel_q;
  logic pal_sel_q;
  logic map_sel_q;
  logic [mpu_data_width-1:0] rdata_mux;

  // Page 0 is fixed, other pages go through the bank
  assign page = mpu_addr[mpu_addr_width-1:page_offset_width];
  assign int_addr = {(page == '0) ? page : bank, mpu_addr[page_offset_width-1:0]};

  assign reg_sel = (int_addr - main_reg_base) < num_main_regs;
  assign pal_sel = (int_addr - pal_addr_base) < pal_addr_length;
  assign map_sel = (int_addr - tilemap_addr_base) < tilemap_addr_length;

  // One strobe per transaction, host holds the rest stable
  assign acc_en = (state == bus_idle) && mpu_req;
  assign acc_wr = mpu_wr;
  assign acc_be = mpu_be;
  assign wdata = mpu_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= bus_idle;
      mpu_ack <= 1'b0;
      reg_sel_q <= 1'b0;
      pal_sel_q <= 1'b0;
      map_sel_q <= 1'b0;
    end else begin
      case (state)
        bus_idle: if (mpu_req) begin
          state <= bus_access;
          reg_sel_q <= reg_sel;
          pal_sel_q <= pal_sel;
          map_sel_q <= map_sel;
        end
        bus_access: begin  // Target read data arrives here
          state <= bus_hold;
          mpu_ack <= 1'b1;
        end
        bus_hold: if (!mpu_req) begin
          state <= bus_idle;
          mpu_ack <= 1'b0;
        end
        default: state <= bus_idle;
      endcase
    end
  end

  // Unmapped reads give zero
  assign rdata_mux = reg_sel_q ? reg_rdata :
                     pal_sel_q ? pal_rdata :
                     map_sel_q ? map_rdata : '0;

  always_ff @(posedge clk) begin
    if (state == bus_access) mpu_rdata <= rdata_mux;  // Held while ack high
  end

endmodule

//--- hw/main_registers.sv
`timescale 1ns/100ps

module main_registers (
  input  logic clk,
  input  logic reset,
  input  logic en,
  input  logic wr,
  input  logic [1:0] be,
  input  logic [2:0] addr,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] wdata,
  input  logic [3:0] status,
  input  logic [gfx_video_pkg::hcount_width-1:0] scan_x,
  input  logic [gfx_video_pkg::vcount_width-1:0] scan_y,
  output logic [gfx_map_pkg::mpu_data_width-1:0] rdata,
  output logic display_en,
  output logic [gfx_map_pkg::page_index_width-1:0] bank,
  output logic [gfx_video_pkg::hcount_width-1:0] scroll_x,
  output logic [gfx_video_pkg::vcount_width-1:0] scroll_y
);
  import gfx_map_pkg::*;
  import gfx_video_pkg::*;

  reg_index_e idx;
  logic [mpu_data_width-1:0] mem_ctrl_q;
  logic [mpu_data_width-1:0] scroll_x_q;
  logic [mpu_data_width-1:0] scroll_y_q;
  logic [mpu_data_width-1:0] spare_q;

  function automatic logic [mpu_data_width-1:0] merge_bytes(
    input logic [mpu_data_width-1:0] old_val,
    input logic [mpu_data_width-1:0] new_val,
    input logic [1:0] byte_en
  );
    logic [mpu_data_width-1:0] result;
    result = old_val;
    if (byte_en[0]) result[7:0] = new_val[7:0];
    if (byte_en[1]) result[15:8] = new_val[15:8];
    return result;
  endfunction

  assign idx = reg_index_e'(addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_ctrl_q <= '0;
      scroll_x_q <= '0;
      scroll_y_q <= '0;
      spare_q <= '0;
    end else if (en && wr) begin
      case (idx)
        reg_mem_ctrl: mem_ctrl_q <= merge_bytes(mem_ctrl_q, wdata, be);
        reg_scroll_x: scroll_x_q <= merge_bytes(scroll_x_q, wdata, be);
        reg_scroll_y: scroll_y_q <= merge_bytes(scroll_y_q, wdata, be);
        reg_spare: spare_q <= merge_bytes(spare_q, wdata, be);
        default: ;  // Read-only registers
      endcase
    end
  end

  // Live values for the read-only entries
  always_ff @(posedge clk) begin
    if (en) begin
      case (idx)
        reg_id: rdata <= id_reg_value;
        reg_mem_ctrl: rdata <= mem_ctrl_q;
        reg_scroll_x: rdata <= scroll_x_q;
        reg_scroll_y: rdata <= scroll_y_q;
        reg_output_status: rdata <= {{(mpu_data_width-4){1'b0}}, status};
        reg_scan_x: rdata <= {{(mpu_data_width-hcount_width){1'b0}}, scan_x};
        reg_scan_y: rdata <= {{(mpu_data_width-vcount_width){1'b0}}, scan_y};
        reg_spare: rdata <= spare_q;
      endcase
    end
  end

  assign display_en = mem_ctrl_q[mem_ctrl_enable_bit];
  assign bank = mem_ctrl_q[mem_ctrl_bank_lsb +: page_index_width];
  assign scroll_x = scroll_x_q[hcount_width-1:0];  // Upper bits kept for readback
  assign scroll_y = scroll_y_q[vcount_width-1:0];

endmodule

//--- hw/dual_port_ram.sv
`timescale 1ns/100ps

module dual_port_ram #(
  parameter int data_bytes = 2,
  parameter int depth = 256
) (
  input  logic clk,
  input  logic a_en,
  input  logic a_wr,
  input  logic [data_bytes-1:0] a_be,
  input  logic [$clog2(depth)-1:0] a_addr,
  input  logic [data_bytes*8-1:0] a_wdata,
  input  logic [$clog2(depth)-1:0] b_addr,
  output logic [data_bytes*8-1:0] a_rdata,
  output logic [data_bytes*8-1:0] b_rdata
);

  logic [data_bytes*8-1:0] mem [depth];

  // Host port, read returns the old word on a write
  always_ff @(posedge clk) begin
    if (a_en) begin
      for (int i = 0; i < data_bytes; i++) begin
        if (a_wr && a_be[i]) mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
      end
      a_rdata <= mem[a_addr];
    end
  end

  // Renderer port reads every cycle
  always_ff @(posedge clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

//--- hw/display_timing.sv
`timescale 1ns/100ps

module display_timing (
  input  logic clk,
  input  logic reset,
  output logic [gfx_video_pkg::hcount_width-1:0] h_pos,
  output logic [gfx_video_pkg::vcount_width-1:0] v_pos,
  output logic h_sync,
  output logic v_sync,
  output logic h_blank,
  output logic v_blank,
  output logic [gfx_video_pkg::hcount_width-1:0] scan_x,
  output logic [gfx_video_pkg::vcount_width-1:0] scan_y
);
  import gfx_video_pkg::*;

  logic [hcount_width-1:0] h_cnt;
  logic [vcount_width-1:0] v_cnt;

  // One pixel per clock
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == h_total - 1'b1) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == v_total - 1'b1) ? '0 : v_cnt + 1'b1;  // Frame wrap
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign h_pos = h_cnt;
  assign v_pos = v_cnt;

  // Active low pulses
  assign h_sync = !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end));
  assign v_sync = !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));

  assign h_blank = h_cnt >= h_visible;
  assign v_blank = v_cnt >= v_visible;

  assign scan_x = h_blank ? '0 : h_cnt;
  assign scan_y = v_blank ? '0 : v_cnt;

endmodule

//--- hw/tile_renderer.sv
`timescale 1ns/100ps

module tile_renderer (
  input  logic clk,
  input  logic reset,
  input  logic [gfx_video_pkg::hcount_width-1:0] h_pos,
  input  logic [gfx_video_pkg::vcount_width-1:0] v_pos,
  input  logic h_sync,
  input  logic v_sync,
  input  logic h_blank,
  input  logic v_blank,
  input  logic display_en,
  input  logic [gfx_video_pkg::hcount_width-1:0] scroll_x,
  input  logic [gfx_video_pkg::vcount_width-1:0] scroll_y,
  input  logic [gfx_video_pkg::map_word_width-1:0] map_data,
  input  logic [gfx_video_pkg::pal_entry_bytes*8-1:0] pal_data,
  output logic [gfx_video_pkg::map_addr_width-1:0] map_addr,
  output logic [gfx_video_pkg::pal_index_width-1:0] pal_addr,
  output logic vga_hsync,
  output logic vga_vsync,
  output logic [gfx_video_pkg::rgb_depth-1:0] vga_rgb
);
  import gfx_video_pkg::*;

  logic [hcount_width-1:0] map_x;
  logic [vcount_width-1:0] map_y;
  logic [1:0] hsync_d;
  logic [1:0] vsync_d;
  logic [1:0] visible_d;

  // Stage 1: scrolled position, map wraps at 512x256 pixels
  assign map_x = h_pos + scroll_x;
  assign map_y = v_pos + scroll_y;
  assign map_addr = {map_y[tile_shift +: map_row_bits], map_x[tile_shift +: map_col_bits]};

  // Stage 2: map word from the RAM selects the palette entry
  assign pal_addr = map_data[pal_index_width-1:0];

  // Sync and visibility follow the two RAM reads
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync_d <= 2'b11;
      vsync_d <= 2'b11;
      visible_d <= 2'b00;
    end else begin
      hsync_d <= {hsync_d[0], h_sync};
      vsync_d <= {vsync_d[0], v_sync};
      visible_d <= {visible_d[0], display_en && !h_blank && !v_blank};
    end
  end

  assign vga_hsync = hsync_d[1];
  assign vga_vsync = vsync_d[1];

  // Palette output register holds the entry, top 6 bits of each byte
  assign vga_rgb = visible_d[1] ? {pal_data[7 -: color_bits],    // Red
                                   pal_data[15 -: color_bits],   // Green
                                   pal_data[23 -: color_bits]}   // Blue
                                : '0;

endmodule

//--- hw/tile_gfx_top.sv
`timescale 1ns/100ps

module tile_gfx_top (
  input  logic clk,
  input  logic reset,
  input  logic mpu_req,
  input  logic mpu_wr,
  input  logic [1:0] mpu_be,
  input  logic [gfx_map_pkg::mpu_addr_width-1:0] mpu_addr,
  input  logic [gfx_map_pkg::mpu_data_width-1:0] mpu_wdata,
  output logic mpu_ack,
  output logic [gfx_map_pkg::mpu_data_width-1:0] mpu_rdata,
  output logic vga_hsync,
  output logic vga_vsync,
  output logic [gfx_video_pkg::rgb_depth-1:0] vga_rgb
);
  import gfx_map_pkg::*;
  import gfx_video_pkg::*;

  logic acc_en;
  logic acc_wr;
  logic [1:0] acc_be;
  logic [mpu_addr_width-1:0] int_addr;
  logic [mpu_data_width-1:0] wdata;
  logic reg_sel;
  logic pal_sel;
  logic map_sel;
  logic [mpu_data_width-1:0] reg_rdata;
  logic [mpu_data_width-1:0] pal_rdata;
  logic [mpu_data_width-1:0] map_rdata;
  logic display_en;
  logic [page_index_width-1:0] bank;
  logic [hcount_width-1:0] scroll_x;
  logic [vcount_width-1:0] scroll_y;
  logic [hcount_width-1:0] h_pos;
  logic [vcount_width-1:0] v_pos;
  logic h_sync;
  logic v_sync;
  logic h_blank;
  logic v_blank;
  logic [hcount_width-1:0] scan_x;
  logic [vcount_width-1:0] scan_y;
  logic [map_addr_width-1:0] map_addr;
  logic [map_word_width-1:0] map_data;
  logic [pal_index_width-1:0] pal_addr;
  logic [pal_entry_bytes*8-1:0] pal_data;
  logic [pal_entry_bytes*8-1:0] pal_q;
  logic [pal_entry_bytes-1:0] pal_be;
  logic pal_odd;

  mpu_bus_decode decode (
    .clk(clk), .reset(reset),
    .mpu_req(mpu_req), .mpu_wr(mpu_wr), .mpu_be(mpu_be),
    .mpu_addr(mpu_addr), .mpu_wdata(mpu_wdata), .bank(bank),
    .reg_rdata(reg_rdata), .pal_rdata(pal_rdata), .map_rdata(map_rdata),
    .mpu_ack(mpu_ack), .mpu_rdata(mpu_rdata),
    .acc_en(acc_en), .acc_wr(acc_wr), .acc_be(acc_be),
    .int_addr(int_addr), .wdata(wdata),
    .reg_sel(reg_sel), .pal_sel(pal_sel), .map_sel(map_sel)
  );

  main_registers registers (
    .clk(clk), .reset(reset),
    .en(acc_en && reg_sel), .wr(acc_wr), .be(acc_be),
    .addr(int_addr[2:0]), .wdata(wdata),
    .status({v_blank, h_blank, v_sync, h_sync}),
    .scan_x(scan_x), .scan_y(scan_y),
    .rdata(reg_rdata), .display_en(display_en), .bank(bank),
    .scroll_x(scroll_x), .scroll_y(scroll_y)
  );

  // Even word holds red and green, odd word holds blue in its low byte
  assign pal_odd = int_addr[0];
  assign pal_be = {pal_odd & acc_be[0], ~pal_odd & acc_be[1], ~pal_odd & acc_be[0]};
  assign pal_rdata = pal_odd ? {8'h00, pal_q[23:16]} : pal_q[15:0];  // Address still held

  dual_port_ram #(.data_bytes(pal_entry_bytes), .depth(1 << pal_index_width)) palette (
    .clk(clk),
    .a_en(acc_en && pal_sel), .a_wr(acc_wr), .a_be(pal_be),
    .a_addr(int_addr[pal_index_width:1]), .a_wdata({wdata[7:0], wdata}),
    .b_addr(pal_addr), .a_rdata(pal_q), .b_rdata(pal_data)
  );

  dual_port_ram #(.data_bytes(map_word_width / 8), .depth(1 << map_addr_width)) tilemap (
    .clk(clk),
    .a_en(acc_en && map_sel), .a_wr(acc_wr), .a_be(acc_be),
    .a_addr(int_addr[map_addr_width-1:0]), .a_wdata(wdata),
    .b_addr(map_addr), .a_rdata(map_rdata), .b_rdata(map_data)
  );

  display_timing timing (
    .clk(clk), .reset(reset),
    .h_pos(h_pos), .v_pos(v_pos),
    .h_sync(h_sync), .v_sync(v_sync), .h_blank(h_blank), .v_blank(v_blank),
    .scan_x(scan_x), .scan_y(scan_y)
  );

  tile_renderer renderer (
    .clk(clk), .reset(reset),
    .h_pos(h_pos), .v_pos(v_pos),
    .h_sync(h_sync), .v_sync(v_sync), .h_blank(h_blank), .v_blank(v_blank),
    .display_en(display_en), .scroll_x(scroll_x), .scroll_y(scroll_y),
    .map_data(map_data), .pal_data(pal_data),
    .map_addr(map_addr), .pal_addr(pal_addr),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_rgb(vga_rgb)
  );

endmodule

//--- tb/tile_gfx_assertions.sv
`timescale 1ns/100ps

module tile_gfx_assertions (
  input logic clk,
  input logic reset,
  input logic mpu_req,
  input logic mpu_ack,
  input logic acc_en
);

  ack_low_in_reset: assert property (@(posedge clk) reset |=> !mpu_ack)
    else $error("mpu_ack high after a reset cycle");

  // Rise follows a cycle with req high
  ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
    $rose(mpu_ack) |-> $past(mpu_req))
    else $error("mpu_ack rose without a pending request");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
    (mpu_ack && !mpu_req) |=> !mpu_ack)
    else $error("mpu_ack still high one cycle after req dropped");

  // Each ack rise comes two cycles after a single strobe
  single_access_strobe: assert property (@(posedge clk) disable iff (reset)
    $rose(mpu_ack) |-> ($past(acc_en, 2) && !$past(acc_en)))
    else $error("mpu_ack rose without exactly one access strobe before it");

  no_access_during_ack: assert property (@(posedge clk) disable iff (reset)
    mpu_ack |-> !acc_en)
    else $error("access strobe repeated while mpu_ack was high");

endmodule

bind mpu_bus_decode tile_gfx_assertions bus_checks (
  .clk(clk),
  .reset(reset),
  .mpu_req(mpu_req),
  .mpu_ack(mpu_ack),
  .acc_en(acc_en)
);

//--- tb/tb_tile_gfx.sv
`timescale 1ns/100ps

module tb_tile_gfx;
  import gfx_map_pkg::*;
  import gfx_video_pkg::*;

  logic clk = 1'b0;
  logic reset;
  logic mpu_req;
  logic mpu_wr;
  logic [1:0] mpu_be;
  logic [mpu_addr_width-1:0] mpu_addr;
  logic [mpu_data_width-1:0] mpu_wdata;
  logic mpu_ack;
  logic [mpu_data_width-1:0] mpu_rdata;
  logic vga_hsync;
  logic vga_vsync;
  logic [rgb_depth-1:0] vga_rgb;

  int cycle_count = 0;
  int pix_count = 0;  // Cycles since the last reset edge

  // Testbench copies of the DUT state
  logic [15:0] reg_model [8];
  logic [23:0] pal_model [256];
  logic [15:0] map_model [2048];

  tile_gfx_top DUT (
    .clk(clk), .reset(reset),
    .mpu_req(mpu_req), .mpu_wr(mpu_wr), .mpu_be(mpu_be),
    .mpu_addr(mpu_addr), .mpu_wdata(mpu_wdata),
    .mpu_ack(mpu_ack), .mpu_rdata(mpu_rdata),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_rgb(vga_rgb)
  );

  always #10 clk = ~clk;

  function automatic int line_length();
    return int'(h_total);
  endfunction

  function automatic int frame_length();
    return int'(h_total) * int'(v_total);
  endfunction

  function automatic logic [15:0] apply_byte_enables(input logic [15:0] old_val,
                                                     input logic [15:0] new_val,
                                                     input logic [1:0] be);
    logic [15:0] mask;
    mask = {{8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic is_writable(input reg_index_e idx);
    return idx inside {reg_mem_ctrl, reg_scroll_x, reg_scroll_y, reg_spare};
  endfunction

  // Solid 8x8 tiles on a map that wraps at 64 columns and 32 rows
  function automatic logic [rgb_depth-1:0] expected_rgb(input int h, input int v);
    int col;
    int row;
    logic [15:0] word;
    logic [23:0] entry;
    if (!reg_model[reg_mem_ctrl][0] || h >= int'(h_visible) || v >= int'(v_visible)) begin
      return '0;
    end
    col = ((h + int'(reg_model[reg_scroll_x])) >> tile_shift) % map_cols;
    row = ((v + int'(reg_model[reg_scroll_y])) >> tile_shift) % 32;
    word = map_model[row * map_cols + col];
    entry = pal_model[word[7:0]];
    return {entry[7:2], entry[15:10], entry[23:18]};  // Top 6 bits of each byte
  endfunction

  function automatic logic expected_hsync(input int h);
    int sync_start;
    sync_start = int'(h_visible) + int'(h_front);
    return (h >= sync_start && h < sync_start + int'(h_sync_len)) ? 1'b0 : 1'b1;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic wait_for_ack(input logic level);
    do begin
      @(posedge clk);
      #2;
    end while (mpu_ack !== level);
  endtask

  // Four-phase transfers that start and end 2 ns after an edge
  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data,
                           input logic [1:0] be);
    mpu_addr = addr;
    mpu_wdata = data;
    mpu_be = be;
    mpu_wr = 1'b1;
    mpu_req = 1'b1;
    wait_for_ack(1'b1);
    mpu_req = 1'b0;
    wait_for_ack(1'b0);
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    mpu_addr = addr;
    mpu_be = 2'b11;
    mpu_wr = 1'b0;
    mpu_req = 1'b1;
    wait_for_ack(1'b1);
    data = mpu_rdata;
    mpu_req = 1'b0;
    wait_for_ack(1'b0);
  endtask

  task automatic write_register(input reg_index_e idx, input logic [15:0] data,
                                input logic [1:0] be);
    bus_write({13'd0, idx}, data, be);
    if (is_writable(idx)) reg_model[idx] = apply_byte_enables(reg_model[idx], data, be);
  endtask

  task automatic check_register(input reg_index_e idx);
    logic [15:0] data;
    bus_read({13'd0, idx}, data);
    compare_value($sformatf("register %s", idx.name()), 32'(reg_model[idx]), 32'(data));
  endtask

  task automatic wait_pixel(input int target);
    do begin
      @(posedge clk);
      #2;
    end while (pix_count < target);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 2 * frame_length() + 60000) begin  // Two frames plus setup
      $display("Timeout after %0d cycles without finishing", cycle_count);
      $display("Test failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  always @(posedge clk) begin
    if (reset) pix_count <= 0;
    else pix_count <= pix_count + 1;
  end

  // Output at pix_count n belongs to the pixel of cycle n-2
  always @(negedge clk) begin : compare_pixels
    int n;
    int h;
    int v;
    int frame;
    if (!reset && pix_count >= 2) begin
      n = pix_count - 2;
      frame = n / frame_length();
      h = n % line_length();
      v = (n / line_length()) % int'(v_total);
      if ((frame == 1 || frame == 2) && v < 4) begin
        compare_value($sformatf("rgb frame %0d line %0d pixel %0d", frame, v, h),
                      32'(expected_rgb(h, v)), 32'(vga_rgb));
        compare_value($sformatf("hsync frame %0d line %0d pixel %0d", frame, v, h),
                      32'(expected_hsync(h)), 32'(vga_hsync));
        compare_value($sformatf("vsync frame %0d line %0d", frame, v), 32'd1, 32'(vga_vsync));
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [15:0] data;
    reg_index_e idx;

    reset = 1'b1;
    mpu_req = 1'b0;
    mpu_wr = 1'b0;
    mpu_be = 2'b00;
    mpu_addr = '0;
    mpu_wdata = '0;
    void'($urandom(32'h2a50c21f));
    for (int i = 0; i < 8; i++) reg_model[i] = '0;
    reg_model[reg_id] = id_reg_value;

    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    compare_value("reset ack", 32'd0, 32'(mpu_ack));
    compare_value("reset hsync", 32'd1, 32'(vga_hsync));
    compare_value("reset vsync", 32'd1, 32'(vga_vsync));
    compare_value("reset rgb", 32'd0, 32'(vga_rgb));

    // ID register and unmapped space
    check_register(reg_id);
    write_register(reg_id, 16'hffff, 2'b11);
    check_register(reg_id);
    bus_write(16'h0100, 16'h1234, 2'b11);
    bus_read(16'h0100, data);
    compare_value("unmapped read", 32'd0, 32'(data));

    // Random partial writes with the live status registers left unread
    for (int i = 0; i < 40; i++) begin
      r = $urandom();
      idx = reg_index_e'(r[2:0]);
      write_register(idx, r[31:16], r[4:3]);
      if (!(idx inside {reg_output_status, reg_scan_x, reg_scan_y})) check_register(idx);
    end

    write_register(reg_mem_ctrl, 16'h0100, 2'b11);  // Bank 1 holds the palette
    for (int i = 0; i < 256; i++) begin
      r = $urandom();
      pal_model[i] = r[23:0];
      bus_write(16'h3000 + 16'(2 * i), r[15:0], 2'b11);
      bus_write(16'h3000 + 16'(2 * i + 1), r[31:16], 2'b11);  // Upper byte dropped
    end
    bus_write(16'h300a, 16'hc35a, 2'b10);  // Green of entry 5 only
    pal_model[5][15:8] = 8'hc3;
    bus_write(16'h300b, 16'h00ff, 2'b10);  // Odd word ignores be bit 1
    for (int i = 0; i < 256; i++) begin
      bus_read(16'h3000 + 16'(2 * i), data);
      compare_value($sformatf("palette %0d even", i), 32'(pal_model[i][15:0]), 32'(data));
      bus_read(16'h3000 + 16'(2 * i + 1), data);
      compare_value($sformatf("palette %0d odd", i), 32'(pal_model[i][23:16]), 32'(data));
    end

    write_register(reg_mem_ctrl, 16'h0200, 2'b11);  // Bank 2 holds the tile map
    for (int i = 0; i < 2048; i++) begin
      r = $urandom();
      map_model[i] = r[15:0];
      bus_write(16'ha000 + 16'(i), r[15:0], 2'b11);
    end
    for (int i = 0; i < 2048; i++) begin
      bus_read(16'ha000 + 16'(i), data);
      compare_value($sformatf("tile map %0d", i), 32'(map_model[i]), 32'(data));
    end
    check_register(reg_id);  // Page 0 ignores the bank
    bus_read(16'h1000, data);
    compare_value("page 1 through bank 2", 32'(map_model[0]), 32'(data));

    write_register(reg_scroll_x, 16'd300, 2'b11);
    write_register(reg_scroll_y, 16'd100, 2'b11);
    write_register(reg_mem_ctrl, 16'h0001, 2'b11);
    if (pix_count >= frame_length()) begin
      $display("Setup did not finish within frame 0");
      $display("Test failed");
      $fatal(1, "Setup too long");
    end

    // Frame 1 is checked with display on and frame 2 with display off
    wait_pixel(frame_length() + 5 * line_length());
    write_register(reg_mem_ctrl, 16'h0000, 2'b11);
    wait_pixel(2 * frame_length() + 5 * line_length());

    $display("Test passed");
    $finish;
  end

endmodule

//--- flist.f
hw/gfx_map_pkg.sv
hw/gfx_video_pkg.sv
hw/mpu_bus_decode.sv
hw/main_registers.sv
hw/dual_port_ram.sv
hw/display_timing.sv
hw/tile_renderer.sv
hw/tile_gfx_top.sv
tb/tile_gfx_assertions.sv
tb/tb_tile_gfx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then search the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_tile_gfx -f flist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
